// File: vlog.f
+incdir+source
source/adi_regs_pkg.sv
source/reg_access_if.sv
source/axi_lite_write_ctrl.sv
source/axi_lite_read_ctrl.sv
source/adi_ctrl_regs.sv
source/adi2axis_if.sv
verif/tb_adi2axis_if.sv

// File: Bender.yml
package:
  name: adi2axis_if

sources:
  - include_dirs:
      - source
    files:
      - source/adi_regs_pkg.sv
      - source/reg_access_if.sv
      - source/axi_lite_write_ctrl.sv
      - source/axi_lite_read_ctrl.sv
      - source/adi_ctrl_regs.sv
      - source/adi2axis_if.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_adi2axis_if.sv

// File: verif/tb_adi2axis_if.sv
//////////////////////////////
// Directed tests of the register slave with one transaction per channel
// Inputs change and outputs are sampled on the falling edge
//////////////////////////////

`include "adi_regs_consts.svh"

module tb_adi2axis_if;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 300;
  // Longest wait for any single handshake
  localparam int WAIT_LIMIT      = 50;

  typedef logic [`ADI_AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`ADI_AXI_DATA_W-1:0]   data_t;
  typedef logic [`ADI_AXI_DATA_W/8-1:0] strb_t;

  logic  S_AXI_ACLK;
  logic  S_AXI_ARESETN;
  addr_t awaddr;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  logic [1:0] bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  logic [1:0] rresp;
  logic  rvalid;
  logic  rready;
  data_t ctrl;
  data_t num_bytes;
  data_t stat;

  // Reference copies of the two writable words
  data_t shadow_ctrl;
  data_t shadow_num;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;

  adi2axis_if dut (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (awaddr),
    .S_AXI_AWVALID (awvalid),
    .S_AXI_AWREADY (awready),
    .S_AXI_WDATA   (wdata),
    .S_AXI_WSTRB   (wstrb),
    .S_AXI_WVALID  (wvalid),
    .S_AXI_WREADY  (wready),
    .S_AXI_BRESP   (bresp),
    .S_AXI_BVALID  (bvalid),
    .S_AXI_BREADY  (bready),
    .S_AXI_ARADDR  (araddr),
    .S_AXI_ARVALID (arvalid),
    .S_AXI_ARREADY (arready),
    .S_AXI_RDATA   (rdata),
    .S_AXI_RRESP   (rresp),
    .S_AXI_RVALID  (rvalid),
    .S_AXI_RREADY  (rready),
    .ctrl          (ctrl),
    .num_bytes     (num_bytes),
    .stat          (stat)
  );

  // Free running clock
  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #(CLK_PERIOD/2) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // Budget of a few hundred cycles per test
  initial
  begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired at %0t ns, a test never finished", $time);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////
  // Checking and model
  //////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic report_wait_timeout(input string what);
    errors++;
    $display("Timeout at %0t ns: DUT never raised %s", $time, what);
  endtask

  // Strobed lanes take the new byte and others keep the old one
  function automatic data_t strobe_merge(input data_t old_w, input data_t new_w, input strb_t s);
    data_t mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
    if (addr[4:2] == 3'd0)
      shadow_ctrl = strobe_merge(shadow_ctrl, data, strb);
    else if (addr[4:2] == 3'd1)
      shadow_num = strobe_merge(shadow_num, data, strb);
  endtask

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  task automatic drive_write(input addr_t addr, input data_t data, input strb_t strb);
    @(negedge S_AXI_ACLK);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
  endtask

  // Handshake completes on the edge after the readies are seen
  task automatic finish_write_accept();
    int n;
    n = 0;
    @(negedge S_AXI_ACLK);
    while (!(awready && wready) && n < WAIT_LIMIT)
    begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    if (n >= WAIT_LIMIT)
      report_wait_timeout("AWREADY and WREADY");
    @(negedge S_AXI_ACLK);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic take_write_resp(input int hold);
    int n;
    n = 0;
    while (!bvalid && n < WAIT_LIMIT)
    begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    if (n >= WAIT_LIMIT)
      report_wait_timeout("BVALID");
    check_eq(bresp, `ADI_RESP_OKAY, "BRESP");
    repeat (hold)
    begin
      @(negedge S_AXI_ACLK);
      check_eq(bvalid, 1'b1, "BVALID held while BREADY low");
    end
    bready = 1'b1;
    @(negedge S_AXI_ACLK);
    bready = 1'b0;
    check_eq(bvalid, 1'b0, "BVALID after response taken");
  endtask

  task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                           input int hold);
    drive_write(addr, data, strb);
    finish_write_accept();
    take_write_resp(hold);
    model_write(addr, data, strb);
  endtask

  task automatic axi_read(input addr_t addr, input int hold, output data_t data);
    int n;
    n = 0;
    @(negedge S_AXI_ACLK);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!arready && n < WAIT_LIMIT)
    begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    if (n >= WAIT_LIMIT)
      report_wait_timeout("ARREADY");
    @(negedge S_AXI_ACLK);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < WAIT_LIMIT)
    begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    if (n >= WAIT_LIMIT)
      report_wait_timeout("RVALID");
    data = rdata;
    check_eq(rresp, `ADI_RESP_OKAY, "RRESP");
    // RDATA must not move under back-pressure
    repeat (hold)
    begin
      @(negedge S_AXI_ACLK);
      check_eq(rvalid, 1'b1, "RVALID held while RREADY low");
      check_eq(rdata, data, "RDATA stable while RREADY low");
    end
    rready = 1'b1;
    @(negedge S_AXI_ACLK);
    rready = 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("%-14s ok", name);
    else
      $display("%-14s %0d errors", name, errors - errors_before);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    int e0;
    e0 = errors;
    check_eq(ctrl, '0, "ctrl after reset");
    check_eq(num_bytes, '0, "num_bytes after reset");
    check_eq({awready, wready, arready, bvalid, rvalid}, '0, "handshake outputs after reset");
    report_test("reset", e0);
  endtask

  task automatic test_full_words();
    int    e0;
    data_t d0;
    data_t d1;
    data_t rd;
    e0 = errors;
    d0 = $random(seed);
    d1 = $random(seed);
    axi_write(5'h00, d0, 4'hF, 0);
    axi_write(5'h04, d1, 4'hF, 0);
    check_eq(ctrl, d0, "ctrl port after full write");
    check_eq(num_bytes, d1, "num_bytes port after full write");
    axi_read(5'h00, 0, rd);
    check_eq(rd, d0, "ctrl read back");
    axi_read(5'h04, 0, rd);
    check_eq(rd, d1, "num_bytes read back");
    report_test("full_words", e0);
  endtask

  task automatic test_byte_strobes();
    int    e0;
    addr_t a;
    data_t rd;
    strb_t strbs[9];
    e0 = errors;
    strbs = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'hA, 4'h0};
    for (int i = 0; i < 9; i++)
    begin
      a = (i % 2 == 0) ? 5'h00 : 5'h04;
      axi_write(a, $random(seed), strbs[i], 0);
      check_eq(ctrl, shadow_ctrl, "ctrl port after strobed write");
      check_eq(num_bytes, shadow_num, "num_bytes port after strobed write");
      axi_read(a, 0, rd);
      check_eq(rd, (a == 5'h00) ? shadow_ctrl : shadow_num, "strobed word read back");
    end
    report_test("byte_strobes", e0);
  endtask

  task automatic test_map_edges();
    int    e0;
    data_t rd;
    e0 = errors;
    @(negedge S_AXI_ACLK);
    stat = $random(seed);
    axi_read(5'h08, 0, rd);
    check_eq(rd, stat, "stat read");
    // Status word and unmapped words accept writes but keep no data
    for (int a = 8; a <= 28; a += 4)
    begin
      axi_write(a[4:0], $random(seed), 4'hF, 0);
      check_eq(ctrl, shadow_ctrl, "ctrl after write to read-only word");
      check_eq(num_bytes, shadow_num, "num_bytes after write to read-only word");
      axi_read(a[4:0], 0, rd);
      check_eq(rd, (a == 8) ? stat : '0, "read of upper map");
    end
    report_test("map_edges", e0);
  endtask

  task automatic test_back_pressure();
    int    e0;
    data_t da;
    data_t db;
    data_t rd;
    data_t st;
    e0 = errors;
    da = $random(seed);
    db = $random(seed);
    drive_write(5'h00, da, 4'hF);
    finish_write_accept();
    // Second write waits behind the unanswered first one
    drive_write(5'h04, db, 4'hF);
    repeat (5)
    begin
      @(negedge S_AXI_ACLK);
      check_eq(bvalid, 1'b1, "BVALID held under back-pressure");
      check_eq(bresp, `ADI_RESP_OKAY, "BRESP under back-pressure");
      check_eq(awready, 1'b0, "AWREADY while response pending");
      check_eq(wready, 1'b0, "WREADY while response pending");
    end
    bready = 1'b1;
    @(negedge S_AXI_ACLK);
    bready = 1'b0;
    model_write(5'h00, da, 4'hF);
    finish_write_accept();
    take_write_resp(0);
    model_write(5'h04, db, 4'hF);
    check_eq(ctrl, shadow_ctrl, "ctrl after back-pressure");
    check_eq(num_bytes, shadow_num, "num_bytes after queued write");
    // stat moves while the read data is held back
    st = stat;
    fork
      axi_read(5'h08, 5, rd);
      begin
        repeat (4) @(negedge S_AXI_ACLK);
        stat = ~st;
      end
    join
    check_eq(rd, st, "read under RREADY back-pressure");
    report_test("back_pressure", e0);
  endtask

  task automatic test_latency();
    int    e0;
    int    n;
    data_t d;
    e0 = errors;
    d = $random(seed);
    drive_write(5'h04, d, 4'hF);
    n = 0;
    while (!bvalid && n < WAIT_LIMIT)
    begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    check_eq(n, 2, "edges from write valids to BVALID");
    bready = 1'b1;
    @(negedge S_AXI_ACLK);
    bready = 1'b0;
    model_write(5'h04, d, 4'hF);
    @(negedge S_AXI_ACLK);
    araddr  = 5'h04;
    arvalid = 1'b1;
    n = 0;
    while (!rvalid && n < WAIT_LIMIT)
    begin
      @(negedge S_AXI_ACLK);
      n++;
    end
    arvalid = 1'b0;
    check_eq(n, 2, "edges from ARVALID to RVALID");
    check_eq(rdata, shadow_num, "RDATA in latency read");
    rready = 1'b1;
    @(negedge S_AXI_ACLK);
    rready = 1'b0;
    report_test("latency", e0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    seed          = 46;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    shadow_ctrl   = '0;
    shadow_num    = '0;
    S_AXI_ARESETN = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    stat          = '0;
    repeat (5) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    test_reset();
    test_full_words();
    test_byte_strobes();
    test_map_edges();
    test_back_pressure();
    test_latency();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: source/adi2axis_if.sv
//////////////////////////////
// AXI4-Lite control slave for the data mover
// Every response is OKAY
//////////////////////////////

module adi2axis_if
  import adi_regs_pkg::*;
(
  // Clock and reset
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,

  // Write address channel
  input  axi_addr_t S_AXI_AWADDR,
  input  logic      S_AXI_AWVALID,
  output logic      S_AXI_AWREADY,

  // Write data channel
  input  axi_data_t S_AXI_WDATA,
  input  axi_strb_t S_AXI_WSTRB,
  input  logic      S_AXI_WVALID,
  output logic      S_AXI_WREADY,

  // Write response channel
  output axi_resp_t S_AXI_BRESP,
  output logic      S_AXI_BVALID,
  input  logic      S_AXI_BREADY,

  // Read address channel
  input  axi_addr_t S_AXI_ARADDR,
  input  logic      S_AXI_ARVALID,
  output logic      S_AXI_ARREADY,

  // Read data channel
  output axi_data_t S_AXI_RDATA,
  output axi_resp_t S_AXI_RRESP,
  output logic      S_AXI_RVALID,
  input  logic      S_AXI_RREADY,

  // Data mover control and status
  output axi_data_t ctrl,
  output axi_data_t num_bytes,
  input  axi_data_t stat
);

  // Shared access port to the register bank
  reg_access_if acc_if ();

  //////////////////////////////
  // Write channels
  //////////////////////////////

  axi_lite_write_ctrl u_write_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .acc           (acc_if.wr_side)
  );

  //////////////////////////////
  // Read channels
  //////////////////////////////

  axi_lite_read_ctrl u_read_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .acc           (acc_if.rd_side)
  );

  //////////////////////////////
  // Register bank
  //////////////////////////////

  // Independent of the bus handshakes, acts on the write pulse only
  adi_ctrl_regs u_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .acc           (acc_if.regs),
    .stat          (stat),
    .ctrl          (ctrl),
    .num_bytes     (num_bytes)
  );

endmodule

// File: source/adi_ctrl_regs.sv
//////////////////////////////
// ctrl and num_bytes are R/W, stat is read only
// Other words read as zero and ignore writes
//////////////////////////////

`include "adi_regs_consts.svh"

module adi_ctrl_regs
  import adi_regs_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  reg_access_if.regs acc,
  input  axi_data_t  stat,
  output axi_data_t  ctrl,
  output axi_data_t  num_bytes
);

  // Replace only the strobed byte lanes
  function automatic axi_data_t merge_bytes(
    input axi_data_t old_word,
    input axi_data_t new_word,
    input axi_strb_t strb
  );
    axi_data_t merged;
    merged = old_word;
    for (int i = 0; i < `ADI_AXI_DATA_W/8; i++)
    begin
      if (strb[i])
        merged[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return merged;
  endfunction

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl      <= '0;
      num_bytes <= '0;
    end
    else if (acc.wr_en)
    begin
      case (acc.wr_idx)
        `ADI_REG_CTRL:
          ctrl <= merge_bytes(ctrl, acc.wr_data, acc.wr_strb);
        `ADI_REG_NUM_BYTES:
          num_bytes <= merge_bytes(num_bytes, acc.wr_data, acc.wr_strb);
        // stat and unmapped words are not writable
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb
  begin
    case (acc.rd_idx)
      `ADI_REG_CTRL:      acc.rd_data = ctrl;
      `ADI_REG_NUM_BYTES: acc.rd_data = num_bytes;
      `ADI_REG_STAT:      acc.rd_data = stat;
      default:            acc.rd_data = '0;
    endcase
  end

endmodule

// File: source/axi_lite_read_ctrl.sv
//////////////////////////////
// AR and R channels; one read at a time
// No new address is taken while RVALID is high
//////////////////////////////

`include "adi_regs_consts.svh"

module axi_lite_read_ctrl
  import adi_regs_pkg::*;
(
  input  logic          S_AXI_ACLK,
  input  logic          S_AXI_ARESETN,
  input  axi_addr_t     araddr,
  input  logic          arvalid,
  output logic          arready,
  output axi_data_t     rdata,
  output axi_resp_t     rresp,
  output logic          rvalid,
  input  logic          rready,
  reg_access_if.rd_side acc
);

  rd_state_t state;
  reg_idx_t  rd_idx_q;
  logic      ar_take;

  // New address sampled only with the data channel empty
  assign ar_take = (state == RD_IDLE) && arvalid;

  //////////////////////////////
  // Channel FSM
  //////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state   <= RD_IDLE;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= '0;
      rdata   <= '0;
    end
    else
    begin
      case (state)
        RD_IDLE:
        begin
          if (ar_take)
          begin
            state   <= RD_ACCEPT;
            arready <= 1'b1;
          end
        end
        // Single cycle arready, then register the looked-up word
        RD_ACCEPT:
        begin
          arready <= 1'b0;
          if (arvalid)
          begin
            state  <= RD_DATA;
            rvalid <= 1'b1;
            rresp  <= `ADI_RESP_OKAY;
            rdata  <= acc.rd_data;
          end
          else
          begin
            state <= RD_IDLE;
          end
        end
        // rdata holds until rready
        RD_DATA:
        begin
          if (rready)
          begin
            state  <= RD_IDLE;
            rvalid <= 1'b0;
          end
        end
        default:
        begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // Read address latch
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (ar_take)
      rd_idx_q <= araddr[`ADI_AXI_ADDR_W-1:`ADI_ADDR_LSB];
  end

  assign acc.rd_idx = rd_idx_q;

endmodule

// File: source/axi_lite_write_ctrl.sv
//////////////////////////////
// AW, W and B channels; AW and W must be valid together
// One write at a time, the next waits until BVALID drops
//////////////////////////////

`include "adi_regs_consts.svh"

module axi_lite_write_ctrl
  import adi_regs_pkg::*;
(
  input  logic          S_AXI_ACLK,
  input  logic          S_AXI_ARESETN,
  input  axi_addr_t     awaddr,
  input  logic          awvalid,
  output logic          awready,
  input  axi_data_t     wdata,
  input  axi_strb_t     wstrb,
  input  logic          wvalid,
  output logic          wready,
  output axi_resp_t     bresp,
  output logic          bvalid,
  input  logic          bready,
  reg_access_if.wr_side acc
);

  wr_state_t state;
  reg_idx_t  wr_idx_q;
  logic      aw_w_valid;
  logic      wr_fire;

  // Address and data both offered
  assign aw_w_valid = awvalid && wvalid;

  // Handshake completes while the readies are up
  assign wr_fire = (state == WR_ACCEPT) && aw_w_valid;

  //////////////////////////////
  // Channel FSM
  //////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      state   <= WR_IDLE;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= '0;
    end
    else
    begin
      case (state)
        // bvalid is always low here, so no response is overwritten
        WR_IDLE:
        begin
          if (aw_w_valid)
          begin
            state   <= WR_ACCEPT;
            awready <= 1'b1;
            wready  <= 1'b1;
          end
        end
        // Readies last one cycle only
        WR_ACCEPT:
        begin
          awready <= 1'b0;
          wready  <= 1'b0;
          if (wr_fire)
          begin
            state  <= WR_RESP;
            bvalid <= 1'b1;
            bresp  <= `ADI_RESP_OKAY;
          end
          else
          begin
            // Master withdrew its request
            state <= WR_IDLE;
          end
        end
        // Hold the response until the master takes it
        WR_RESP:
        begin
          if (bready)
          begin
            state  <= WR_IDLE;
            bvalid <= 1'b0;
          end
        end
        default:
        begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  // Word index captured when the request is first seen
  always_ff @(posedge S_AXI_ACLK)
  begin
    if ((state == WR_IDLE) && aw_w_valid)
      wr_idx_q <= awaddr[`ADI_AXI_ADDR_W-1:`ADI_ADDR_LSB];
  end

  // Bank update lands on the handshake edge
  assign acc.wr_en   = wr_fire;
  assign acc.wr_idx  = wr_idx_q;
  assign acc.wr_data = wdata;
  assign acc.wr_strb = wstrb;

endmodule

// File: source/reg_access_if.sv
//////////////////////////////
// Register access between channel FSMs and bank
// Read data is combinational from the read index
//////////////////////////////

interface reg_access_if
  import adi_regs_pkg::*;
();

  // Write request, valid for one cycle
  logic      wr_en;
  reg_idx_t  wr_idx;
  axi_data_t wr_data;
  axi_strb_t wr_strb;

  // Read lookup
  reg_idx_t  rd_idx;
  axi_data_t rd_data;

  // Write channel controller
  modport wr_side (
    output wr_en,
    output wr_idx,
    output wr_data,
    output wr_strb
  );

  // Read channel controller
  modport rd_side (
    output rd_idx,
    input  rd_data
  );

  // Register bank sees both requests
  modport regs (
    input  wr_en,
    input  wr_idx,
    input  wr_data,
    input  wr_strb,
    input  rd_idx,
    output rd_data
  );

endinterface

// File: source/adi_regs_pkg.sv
//////////////////////////////
// Shared types for the register slave
//////////////////////////////

`include "adi_regs_consts.svh"

package adi_regs_pkg;

  //////////////////////////////
  // Bus vectors
  //////////////////////////////

  // Byte address from the bus
  typedef logic [`ADI_AXI_ADDR_W-1:0] axi_addr_t;
  // One data word
  typedef logic [`ADI_AXI_DATA_W-1:0] axi_data_t;
  // One strobe bit per byte lane
  typedef logic [`ADI_AXI_DATA_W/8-1:0] axi_strb_t;
  // BRESP and RRESP
  typedef logic [1:0] axi_resp_t;
  // Word index into the register map
  typedef logic [`ADI_REG_IDX_W-1:0] reg_idx_t;

  //////////////////////////////
  // Channel FSM states
  //////////////////////////////

  // Write side
  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,
    WR_ACCEPT = 2'd1,
    WR_RESP   = 2'd2
  } wr_state_t;

  // Read side
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,
    RD_ACCEPT = 2'd1,
    RD_DATA   = 2'd2
  } rd_state_t;

endpackage

// File: source/adi_regs_consts.svh
//////////////////////////////
// Fixed map of three 32-bit words; widths are not meant to be changed
//////////////////////////////

`ifndef ADI_REGS_CONSTS_SVH
`define ADI_REGS_CONSTS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// AXI4-Lite data bus
`define ADI_AXI_DATA_W 32
// Byte address covers eight words
`define ADI_AXI_ADDR_W 5

//////////////////////////////
// Word addressing
//////////////////////////////

// Low address bits select a byte inside the word
`define ADI_ADDR_LSB 2
// Word index is the address above the byte offset
`define ADI_REG_IDX_W 3

// Register word indexes
`define ADI_REG_CTRL      3'd0
`define ADI_REG_NUM_BYTES 3'd1
`define ADI_REG_STAT      3'd2

// Only response this slave ever returns
`define ADI_RESP_OKAY 2'b00

`endif
